// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_alu_pipe
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets: test (build and run), clean (remove outputs), help"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); \
	then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: alu_pipe_asserts.sv
// Checks control timing at the top ports only; fail_cnt is read by the testbench hierarchically
`timescale 1ns/1ps

module alu_pipe_asserts (
	input logic                            clk,
	input logic                            rst_n,
	input logic                            instr_valid,
	input logic                            flush,
	input logic                            wb_en,
	input logic [pipe_pkg::reg_addr_w-1:0] wb_rd
);
	import pipe_pkg::*;

	int fail_cnt = 0; // Bumped by every failing assertion

	// --------------------
	// Latency rules
	// --------------------
	// Result seen two sampled edges after instr_valid was driven
	a_en_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> $past(instr_valid, 2))
	else
	begin
		fail_cnt++;
		$error("wb_en high without an instruction two edges earlier");
	end

	a_flush_kills: assert property (@(posedge clk) disable iff (!rst_n)
		(instr_valid && flush) |-> ##2 !wb_en)
	else
	begin
		fail_cnt++;
		$error("flushed instruction still produced wb_en");
	end

	// --------------------
	// Reset and r0
	// --------------------
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> ##1 !wb_en ##1 !wb_en)
	else
	begin
		fail_cnt++;
		$error("wb_en high during or right after reset");
	end

	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> (wb_rd != '0))
	else
	begin
		fail_cnt++;
		$error("write enable reported for register 0");
	end

endmodule

bind alu_pipe_top alu_pipe_asserts u_asserts (.*);

// File: alu_pipe_top.sv
// Fixed latency, results on wb_* one cycle after instr_valid is sampled; no back-pressure
`timescale 1ns/1ps

module alu_pipe_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              instr_valid,
	input  logic [pipe_pkg::word_w-1:0]       instr,
	input  logic                              flush,
	output logic                              wb_en,
	output logic [pipe_pkg::reg_addr_w-1:0]   wb_rd,
	output logic [pipe_pkg::word_w-1:0]       wb_data,
	output logic                              wb_zero,
	output logic                              wb_over
);

	// Stage links
	id_ex_if   idex_bus ();
	rf_read_if rf_bus ();
	ex_mem_if  exmem_bus ();

	decode_stage u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.flush       (flush),
		.rf          (rf_bus.requester),
		.idex        (idex_bus.source)
	);

	execute_stage u_execute (
		.clk   (clk),
		.rst_n (rst_n),
		.idex  (idex_bus.sink),
		.exmem (exmem_bus.execute)
	);

	writeback_stage u_writeback (
		.clk     (clk),
		.rst_n   (rst_n),
		.rf      (rf_bus.responder),
		.exmem   (exmem_bus.writeback),
		.wb_en   (wb_en),
		.wb_rd   (wb_rd),
		.wb_data (wb_data),
		.wb_zero (wb_zero),
		.wb_over (wb_over)
	);

endmodule

// File: decode_stage.sv
// One instruction per instr_valid strobe; flush kills the one being loaded, RF data may be stale
`timescale 1ns/1ps

module decode_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            instr_valid,
	input  logic [pipe_pkg::word_w-1:0]     instr,
	input  logic                            flush,
	rf_read_if.requester                    rf,
	id_ex_if.source                         idex
);
	import pipe_pkg::*;

	instr_u                iw;        // Two views of the incoming word
	alu_ctrl_t             ctrl;
	logic                  use_imm;
	logic [reg_addr_w-1:0] dest;
	logic [word_w-1:0]     imm_ext;
	logic                  wr_ok;     // Legal op with nonzero destination

	assign iw = instr;

	// RF addresses straight from the word
	assign rf.rs_addr = iw.r.rs;
	assign rf.rt_addr = iw.r.rt;

	// --------------------
	// Decode
	// --------------------
	always_comb
	begin
		ctrl    = alu_bad;
		use_imm = 1'b1;
		dest    = iw.i.rt;                   // I-type writes rt
		imm_ext = {16'h0000, iw.i.imm};       // Zero extend unless told otherwise
		case (iw.r.opcode)
			op_rtype:
			begin
				use_imm = 1'b0;
				dest    = iw.r.rd;
				// Low bits of imm carry funct on to execute
				case (iw.r.funct)
					fn_sll:  ctrl = alu_sll;
					fn_srl:  ctrl = alu_srl;
					fn_add:  ctrl = alu_add;
					fn_addu: ctrl = alu_add;
					fn_sub:  ctrl = alu_sub;
					fn_and:  ctrl = alu_and;
					fn_or:   ctrl = alu_or;
					fn_xor:  ctrl = alu_xor;
					fn_nor:  ctrl = alu_nor;
					fn_slt:  ctrl = alu_slt;
					fn_mul:  ctrl = alu_mul;
					default: ctrl = alu_bad;
				endcase
			end
			op_addi:
			begin
				ctrl    = alu_add;
				imm_ext = {{16{iw.i.imm[15]}}, iw.i.imm}; // Sign extend
			end
			op_slti:
			begin
				ctrl    = alu_slt;
				imm_ext = {{16{iw.i.imm[15]}}, iw.i.imm};
			end
			op_andi: ctrl = alu_and;
			op_ori:  ctrl = alu_or;
			op_lui:  ctrl = alu_lui;  // Shift by 16 done in execute
			default: ctrl = alu_bad;
		endcase
	end

	assign wr_ok = (ctrl != alu_bad) && (dest != '0);

	// --------------------
	// ID/EX register
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			idex.valid     <= 1'b0;
			idex.reg_write <= 1'b0;
		end
		else
		begin
			idex.valid     <= instr_valid & ~flush;
			idex.reg_write <= instr_valid & ~flush & wr_ok;
		end
	end

	// Payload, loaded only with a new instruction
	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			idex.alu_ctrl <= ctrl;
			idex.rs       <= iw.r.rs;
			idex.rt       <= iw.r.rt;
			idex.dest     <= dest;
			idex.op_a     <= rf.rs_data;
			idex.op_b     <= rf.rt_data;
			idex.imm      <= imm_ext;
			idex.use_imm  <= use_imm;
			idex.shamt    <= iw.r.shamt;
		end
	end

endmodule

// File: execute_stage.sv
// Forwards from EX/MEM then last write; SLT is unsigned, MUL keeps low word, overflow never traps
`timescale 1ns/1ps

module execute_stage (
	input  logic          clk,
	input  logic          rst_n,
	id_ex_if.sink         idex,
	ex_mem_if.execute     exmem
);
	import pipe_pkg::*;

	logic [word_w-1:0] rs_val;   // rs after forwarding
	logic [word_w-1:0] rt_val;   // rt after forwarding
	logic [word_w-1:0] a;
	logic [word_w-1:0] b;
	logic [word_w-1:0] sum;
	logic [word_w-1:0] diff;
	logic [word_w-1:0] res;
	logic              chk_add;  // ADD or ADDI, not ADDU
	logic              ovf;

	// Newest producer wins, r0 never forwarded
	function automatic logic [word_w-1:0] fwd_pick(
		input logic [reg_addr_w-1:0] src,
		input logic [word_w-1:0]     rd_data
	);
		if (exmem.reg_write && (exmem.rd != '0) && (exmem.rd == src))
			return exmem.result;
		if (exmem.fwd_en && (exmem.fwd_rd != '0) && (exmem.fwd_rd == src))
			return exmem.fwd_data;
		return rd_data;
	endfunction

	// --------------------
	// Operand select
	// --------------------
	always_comb
	begin
		rs_val = fwd_pick(idex.rs, idex.op_a);
		rt_val = fwd_pick(idex.rt, idex.op_b);
	end

	// Shifts take shamt as operand a
	assign a = ((idex.alu_ctrl == alu_sll) || (idex.alu_ctrl == alu_srl)) ?
		{{(word_w-5){1'b0}}, idex.shamt} : rs_val;
	assign b = idex.use_imm ? idex.imm : rt_val;

	// --------------------
	// ALU
	// --------------------
	assign sum  = a + b;
	assign diff = a - b;

	always_comb
	begin
		case (idex.alu_ctrl)
			alu_add: res = sum;
			alu_sub: res = diff;
			alu_and: res = a & b;
			alu_or:  res = a | b;
			alu_xor: res = a ^ b;
			alu_nor: res = ~(a | b);
			alu_slt: res = (a < b) ? 32'd1 : 32'd0; // Unsigned
			alu_mul: res = a * b;                   // Truncated to 32 bits
			alu_sll: res = b << a[4:0];
			alu_srl: res = b >> a[4:0];
			alu_lui: res = b << 16;
			default: res = '0;                      // alu_bad
		endcase
	end

	// R-type keeps funct in imm[5:0], so ADDU can be told apart
	assign chk_add = (idex.alu_ctrl == alu_add) &&
		(idex.use_imm || (idex.imm[5:0] != fn_addu));

	// Signed overflow from sign bits
	always_comb
	begin
		ovf = 1'b0;
		if (chk_add)
			ovf = (a[word_w-1] == b[word_w-1]) && (sum[word_w-1] != a[word_w-1]);
		else if (idex.alu_ctrl == alu_sub)
			ovf = (a[word_w-1] != b[word_w-1]) && (diff[word_w-1] != a[word_w-1]);
	end

	// --------------------
	// EX/MEM register
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			exmem.reg_write <= 1'b0;
		else
			exmem.reg_write <= idex.valid & idex.reg_write;
	end

	always_ff @(posedge clk)
	begin
		if (idex.valid)
		begin
			exmem.rd     <= idex.dest;
			exmem.result <= res;
			exmem.zero   <= (res == '0);
			exmem.over   <= ovf;
		end
	end

endmodule

// File: pipe_ifs.sv
// Point-to-point stage links only; no handshake, each signal is sampled on the next clk edge
`timescale 1ns/1ps

// --------------------
// Decode to execute
// --------------------
interface id_ex_if;
	import pipe_pkg::*;

	logic                  valid;
	alu_ctrl_t             alu_ctrl;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic [reg_addr_w-1:0] dest;     // rd or rt by format
	logic [word_w-1:0]     op_a;     // RF read of rs
	logic [word_w-1:0]     op_b;     // RF read of rt
	logic [word_w-1:0]     imm;      // Already extended
	logic                  use_imm;
	logic [4:0]            shamt;
	logic                  reg_write;

	modport source (output valid, alu_ctrl, rs, rt, dest, op_a, op_b, imm, use_imm,
		shamt, reg_write);
	modport sink (input valid, alu_ctrl, rs, rt, dest, op_a, op_b, imm, use_imm,
		shamt, reg_write);
endinterface

// --------------------
// Register file read port
// --------------------
interface rf_read_if;
	import pipe_pkg::*;

	logic [reg_addr_w-1:0] rs_addr;
	logic [reg_addr_w-1:0] rt_addr;
	logic [word_w-1:0]     rs_data; // Combinational, r0 reads 0
	logic [word_w-1:0]     rt_data;

	modport requester (output rs_addr, rt_addr, input rs_data, rt_data);
	modport responder (input rs_addr, rt_addr, output rs_data, rt_data);
endinterface

// --------------------
// Execute to writeback, plus forwarding back
// --------------------
interface ex_mem_if;
	import pipe_pkg::*;

	// Result path
	logic                  reg_write; // Valid already folded in
	logic [reg_addr_w-1:0] rd;
	logic [word_w-1:0]     result;
	logic                  zero;
	logic                  over;

	// Last write held in writeback
	logic                  fwd_en;
	logic [reg_addr_w-1:0] fwd_rd;
	logic [word_w-1:0]     fwd_data;

	modport execute (output reg_write, rd, result, zero, over,
		input fwd_en, fwd_rd, fwd_data);
	modport writeback (input reg_write, rd, result, zero, over,
		output fwd_en, fwd_rd, fwd_data);
endinterface

// File: pipe_pkg.sv
// Encodings cover only the supported MIPS32 subset; anything else decodes to alu_bad
package pipe_pkg;

	// --------------------
	// Widths
	// --------------------
	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;

	// --------------------
	// Opcodes
	// --------------------
	localparam logic [5:0] op_rtype = 6'h00; // SPECIAL, decoded by funct
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_slti  = 6'h0a;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lui   = 6'h0f;

	// R-type function codes
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_mul  = 6'h18; // Low word only
	localparam logic [5:0] fn_add  = 6'h20;
	localparam logic [5:0] fn_addu = 6'h21; // Same ALU op as add, no overflow flag
	localparam logic [5:0] fn_sub  = 6'h22;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_nor  = 6'h27;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// --------------------
	// ALU control codes
	// --------------------
	typedef logic [3:0] alu_ctrl_t;

	localparam alu_ctrl_t alu_add = 4'h0;
	localparam alu_ctrl_t alu_sub = 4'h1;
	localparam alu_ctrl_t alu_and = 4'h2;
	localparam alu_ctrl_t alu_or  = 4'h3;
	localparam alu_ctrl_t alu_xor = 4'h4;
	localparam alu_ctrl_t alu_nor = 4'h5;
	localparam alu_ctrl_t alu_slt = 4'h6; // Unsigned compare
	localparam alu_ctrl_t alu_mul = 4'h7;
	localparam alu_ctrl_t alu_sll = 4'ha;
	localparam alu_ctrl_t alu_srl = 4'hb;
	localparam alu_ctrl_t alu_lui = 4'hc;
	localparam alu_ctrl_t alu_bad = 4'hf; // Illegal opcode or funct

	// --------------------
	// Instruction word views
	// --------------------
	typedef struct packed {
		logic [5:0]            opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [15:0]           imm;
	} i_fmt_t;

	// Same 32 bits, two layouts
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

// File: tb.f
pipe_pkg.sv
pipe_ifs.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
alu_pipe_top.sv
alu_pipe_asserts.sv
tb_alu_pipe.sv

// File: tb_alu_pipe.sv
// Model assumes in-order sequential semantics; results checked two edges after each drive
`timescale 1ns/1ps

module tb_alu_pipe;
	import pipe_pkg::*;

	localparam int n_reads = 62;   // Reset readback plus seeding
	localparam int n_rand  = 64;
	localparam int n_dep   = 36;
	localparam int n_misc  = 18;   // Overflow, r0, illegal, flush, drain
	localparam int n_instr = n_reads + n_rand + n_dep + n_misc;

	typedef struct {
		logic        en;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        ov;
	} exp_t;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic        instr_valid = 1'b0;
	logic [31:0] instr = '0;
	logic        flush = 1'b0;
	logic        wb_en, wb_zero, wb_over;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;

	logic [31:0] mregs [0:31];     // Reference register file
	exp_t        exp_q [$];
	int          err_cnt = 0;
	int unsigned seed_val;

	alu_pipe_top u_alu_pipe_top (.*);

	always #10 clk = ~clk;

	// --------------------
	// Reference model
	// --------------------
	function automatic exp_t model_exec(input instr_u w);
		exp_t        e;
		logic [31:0] rs_v, rt_v, se, ze;
		longint      s;
		logic        legal;
		rs_v = mregs[w.r.rs];
		rt_v = mregs[w.r.rt];
		se = {{16{w.i.imm[15]}}, w.i.imm};
		ze = {16'h0, w.i.imm};
		legal = 1'b1;
		e.ov = 1'b0;
		e.rd = w.i.rt;
		e.data = '0;
		s = 0;
		case (w.r.opcode)
			op_rtype:
			begin
				e.rd = w.r.rd;
				case (w.r.funct)
					fn_sll:  e.data = rt_v << w.r.shamt;
					fn_srl:  e.data = rt_v >> w.r.shamt;
					fn_add:  s = longint'($signed(rs_v)) + longint'($signed(rt_v));
					fn_addu: e.data = rs_v + rt_v;
					fn_sub:  s = longint'($signed(rs_v)) - longint'($signed(rt_v));
					fn_and:  e.data = rs_v & rt_v;
					fn_or:   e.data = rs_v | rt_v;
					fn_xor:  e.data = rs_v ^ rt_v;
					fn_nor:  e.data = ~(rs_v | rt_v);
					fn_slt:  e.data = {31'd0, rs_v < rt_v}; // Unsigned by design
					fn_mul:  e.data = rs_v * rt_v;          // Low word
					default: legal = 1'b0;
				endcase
				if (w.r.funct inside {fn_add, fn_sub})
					e.data = s[31:0];
			end
			op_addi:
			begin
				s = longint'($signed(rs_v)) + longint'($signed(se));
				e.data = s[31:0];
			end
			op_slti: e.data = {31'd0, rs_v < se};
			op_andi: e.data = rs_v & ze;
			op_ori:  e.data = rs_v | ze;
			op_lui:  e.data = {w.i.imm, 16'h0};
			default: legal = 1'b0;
		endcase
		// Signed range check on the wide sum
		if (s > 64'sd2147483647 || s < -64'sd2147483648)
			e.ov = 1'b1;
		e.en = legal && (e.rd != 0);
		if (!legal)
			e.data = '0;
		return e;
	endfunction

	function automatic logic [31:0] rtype(input logic [5:0] fn, input int rd, input int rs,
		input int rt, input int sh);
		instr_u w;
		w.r = '{op_rtype, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
		return w;
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input int rt, input int rs,
		input logic [15:0] imm);
		instr_u w;
		w.i = '{op, rs[4:0], rt[4:0], imm};
		return w;
	endfunction

	// --------------------
	// Drive tasks
	// --------------------
	task automatic issue(input logic [31:0] w, input logic fl = 1'b0);
		exp_t e;
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= w;
		flush       <= fl;
		e = model_exec(w);
		if (fl)
			e.en = 1'b0;               // Flushed, no write
		if (e.en)
			mregs[e.rd] = e.data;
		exp_q.push_back(e);
	endtask

	task automatic idle();
		exp_t e;
		@(posedge clk);
		instr_valid <= 1'b0;
		flush       <= 1'b0;
		e = '{1'b0, 5'd0, 32'd0, 1'b0};
		exp_q.push_back(e);
	endtask

	// Compare oldest entry once it reaches the ports
	always @(negedge clk)
	begin
		exp_t e;
		if (rst_n && exp_q.size() == 3)
		begin
			e = exp_q.pop_front();
			if (wb_en !== e.en)
			begin
				err_cnt++;
				$display("error @%0t: wb_en %b, expected %b", $time, wb_en, e.en);
			end
			else if (e.en && (wb_rd !== e.rd || wb_data !== e.data || wb_over !== e.ov ||
				wb_zero !== (e.data == 0)))
			begin
				err_cnt++;
				$display("error @%0t: r%0d=%h ov=%b, expected r%0d=%h ov=%b", $time,
					wb_rd, wb_data, wb_over, e.rd, e.data, e.ov);
			end
		end
	end

	// --------------------
	// Stimulus
	// --------------------
	initial
	begin
		logic [5:0] fns [11];
		logic [5:0] ops [5];
		int         k;
		fns = '{fn_sll, fn_srl, fn_add, fn_addu, fn_sub, fn_and, fn_or, fn_xor, fn_nor,
			fn_slt, fn_mul};
		ops = '{op_addi, op_slti, op_andi, op_ori, op_lui};
		seed_val = $urandom(32'heb84_925e);
		for (int i = 0; i < 32; i++)
			mregs[i] = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 1; i < 32; i++)
			issue(rtype(fn_or, i, i, 0, 0));          // All must read zero
		for (int i = 1; i < 32; i++)
			issue(itype(op_ori, i, 0, 16'($urandom))); // Seed known values
		// Every function four times, random registers and operands
		for (int i = 0; i < n_rand; i++)
		begin
			k = i % 16;
			if (k < 11)
				issue(rtype(fns[k], $urandom % 32, $urandom % 32, $urandom % 32, $urandom));
			else
				issue(itype(ops[k-11], $urandom % 32, $urandom % 32, 16'($urandom)));
		end
		// Forwarding at distance 1, 2 and 3
		for (int d = 1; d <= 3; d++)
			repeat (4)
			begin
				issue(rtype(fn_add, 5, $urandom % 32, $urandom % 32, 0));
				repeat (d - 1)
					issue(itype(op_ori, 20, 0, 16'($urandom)));
				issue(rtype(fn_xor, 6, 5, 5 - ($urandom % 2), 0));
			end
		// Signed overflow cases
		issue(itype(op_lui, 7, 0, 16'h7fff));
		issue(itype(op_ori, 7, 7, 16'hffff));
		issue(itype(op_lui, 8, 0, 16'h8000));
		issue(rtype(fn_add, 9, 7, 7, 0));
		issue(rtype(fn_addu, 10, 7, 7, 0));
		issue(rtype(fn_sub, 11, 8, 7, 0));
		issue(itype(op_addi, 12, 7, 16'h0001));
		// r0 writes and illegal encodings
		issue(rtype(fn_add, 0, 1, 2, 0));
		issue(rtype(6'h3f, 13, 1, 2, 0));
		issue(itype(6'h3f, 13, 1, 16'h1234));
		issue(rtype(fn_or, 14, 0, 0, 0));
		issue(rtype(fn_or, 15, 13, 0, 0));
		// Flushed write leaves old value
		issue(itype(op_ori, 16, 0, 16'h1234), 1'b1);
		issue(rtype(fn_or, 17, 16, 0, 0));
		issue(rtype(fn_or, 18, 0, 16, 0));
		repeat (3)
			idle();
		// Last compare runs on the first of these edges
		repeat (2) @(negedge clk);
		$display("errors: %0d, assertion failures: %0d", err_cnt,
			u_alu_pipe_top.u_asserts.fail_cnt);
		if (err_cnt == 0 && u_alu_pipe_top.u_asserts.fail_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#((n_instr + 20) * 20);
		$display("timeout, the run did not reach its end in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: writeback_stage.sv
// RF cleared by reset, r0 hardwired to zero; reads are combinational and see writes a cycle late
`timescale 1ns/1ps

module writeback_stage (
	input  logic                              clk,
	input  logic                              rst_n,
	rf_read_if.responder                      rf,
	ex_mem_if.writeback                       exmem,
	output logic                              wb_en,
	output logic [pipe_pkg::reg_addr_w-1:0]   wb_rd,
	output logic [pipe_pkg::word_w-1:0]       wb_data,
	output logic                              wb_zero,
	output logic                              wb_over
);
	import pipe_pkg::*;

	logic [word_w-1:0] regs [0:(1<<reg_addr_w)-1];
	logic              do_write;

	assign do_write = exmem.reg_write && (exmem.rd != '0); // r0 stays zero

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < (1 << reg_addr_w); i++)
				regs[i] <= '0;
		end
		else if (do_write)
			regs[exmem.rd] <= exmem.result;
	end

	assign rf.rs_data = (rf.rs_addr == '0) ? '0 : regs[rf.rs_addr];
	assign rf.rt_data = (rf.rt_addr == '0) ? '0 : regs[rf.rt_addr];

	// --------------------
	// Last write, for forwarding
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			exmem.fwd_en <= 1'b0;
		else if (do_write)
			exmem.fwd_en <= 1'b1; // Stays set, always the newest write
	end

	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			exmem.fwd_rd   <= exmem.rd;
			exmem.fwd_data <= exmem.result;
		end
	end

	// Result ports straight off EX/MEM
	assign wb_en   = exmem.reg_write;
	assign wb_rd   = exmem.rd;
	assign wb_data = exmem.result;
	assign wb_zero = exmem.zero;
	assign wb_over = exmem.over;

endmodule
